// File: Makefile
# Verilator flow for mini_mips
# make          build and run the regression
# make lint     lint the RTL top and the testbench
# make clean    remove build products and the log

VERILATOR ?= verilator
TOP       ?= tb_mips_core
RTL_TOP   ?= mips_core
FILELIST  ?= mini_mips.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

RTL_SRCS := hdl/mips_pkg.sv hdl/fetch_stage.sv hdl/reg_file.sv hdl/decode_stage.sv \
            hdl/execute_stage.sv hdl/memory_stage.sv hdl/mips_core.sv
TB_SRCS  := testbench/tb_mips_core.sv
SIM_BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -qx "Regression passed" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/decode_stage.sv
/*
 * instruction decode, operand bypass and load-use stall
 * owns the decode to execute register
 */
module decode_stage (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  mips_pkg::fetch_t                  fetch_i,
    input  logic [mips_pkg::DATA_W-1:0]       rdata_a_i,
    input  logic [mips_pkg::DATA_W-1:0]       rdata_b_i,
    input  mips_pkg::wb_t                     ex_fwd_i,
    input  mips_pkg::wb_t                     mem_fwd_i,
    output logic [mips_pkg::REG_ADDR_W-1:0]   raddr_a_o,
    output logic [mips_pkg::REG_ADDR_W-1:0]   raddr_b_o,
    output logic                              stall_o,
    output mips_pkg::id_ex_t                  id_ex_o
);

    mips_pkg::inst_u             inst;
    mips_pkg::id_ex_t            id_ex_d;
    mips_pkg::id_ex_t            id_ex_q;
    logic [mips_pkg::DATA_W-1:0] src_a;
    logic [mips_pkg::DATA_W-1:0] src_b;
    logic [mips_pkg::DATA_W-1:0] imm_sext;
    logic [mips_pkg::DATA_W-1:0] imm_zext;
    logic                        use_a;
    logic                        use_b;
    logic                        hazard_a;
    logic                        hazard_b;

    // execute result beats memory result beats register file
    function automatic logic [mips_pkg::DATA_W-1:0] bypass(
        input logic [mips_pkg::REG_ADDR_W-1:0] idx,
        input logic [mips_pkg::DATA_W-1:0]     rf_data,
        input mips_pkg::wb_t                   ex_fwd,
        input mips_pkg::wb_t                   mem_fwd
    );
        logic [mips_pkg::DATA_W-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (ex_fwd.we && ex_fwd.dest == idx) begin
            val = ex_fwd.data;
        end else if (mem_fwd.we && mem_fwd.dest == idx) begin
            val = mem_fwd.data;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    assign inst      = fetch_i.inst;
    assign raddr_a_o = inst.r.rs;
    assign raddr_b_o = inst.r.rt;

    assign src_a    = bypass(inst.r.rs, rdata_a_i, ex_fwd_i, mem_fwd_i);
    assign src_b    = bypass(inst.r.rt, rdata_b_i, ex_fwd_i, mem_fwd_i);
    assign imm_sext = {{16{inst.i.imm[15]}}, inst.i.imm};
    assign imm_zext = {16'h0000, inst.i.imm};

    always_comb begin
        id_ex_d       = '0;
        id_ex_d.valid = 1'b1;
        use_a         = 1'b1;
        use_b         = 1'b0;
        case (inst.r.opcode)
            mips_pkg::OP_SPECIAL: begin
                use_b              = 1'b1;
                id_ex_d.op_a       = src_a;
                id_ex_d.op_b       = src_b;
                id_ex_d.dest       = inst.r.rd;
                id_ex_d.we         = 1'b1;
                case (inst.r.funct)
                    mips_pkg::FN_ADDU: id_ex_d.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: id_ex_d.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  id_ex_d.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   id_ex_d.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  id_ex_d.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  id_ex_d.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL: begin
                        id_ex_d.alu_op = mips_pkg::ALU_SLL;
                        id_ex_d.op_a   = {{(mips_pkg::DATA_W - 5){1'b0}}, inst.r.shamt};
                        use_a          = 1'b0;    // shift amount, not rs
                    end
                    default: id_ex_d.valid = 1'b0;
                endcase
            end
            mips_pkg::OP_ORI, mips_pkg::OP_ANDI, mips_pkg::OP_XORI: begin
                id_ex_d.op_a = src_a;
                id_ex_d.op_b = imm_zext;
                id_ex_d.dest = inst.i.rt;
                id_ex_d.we   = 1'b1;
                if (inst.i.opcode == mips_pkg::OP_ORI) begin
                    id_ex_d.alu_op = mips_pkg::ALU_OR;
                end else if (inst.i.opcode == mips_pkg::OP_ANDI) begin
                    id_ex_d.alu_op = mips_pkg::ALU_AND;
                end else begin
                    id_ex_d.alu_op = mips_pkg::ALU_XOR;
                end
            end
            mips_pkg::OP_ADDIU, mips_pkg::OP_LW: begin
                id_ex_d.alu_op  = mips_pkg::ALU_ADD;
                id_ex_d.op_a    = src_a;
                id_ex_d.op_b    = imm_sext;
                id_ex_d.dest    = inst.i.rt;
                id_ex_d.we      = 1'b1;
                id_ex_d.is_load = (inst.i.opcode == mips_pkg::OP_LW);
            end
            mips_pkg::OP_LUI: begin
                use_a          = 1'b0;
                id_ex_d.alu_op = mips_pkg::ALU_LUI;
                id_ex_d.op_b   = imm_zext;
                id_ex_d.dest   = inst.i.rt;
                id_ex_d.we     = 1'b1;
            end
            mips_pkg::OP_SW: begin
                use_b              = 1'b1;    // store data from rt
                id_ex_d.alu_op     = mips_pkg::ALU_ADD;
                id_ex_d.op_a       = src_a;
                id_ex_d.op_b       = imm_sext;
                id_ex_d.store_data = src_b;
                id_ex_d.is_store   = 1'b1;
            end
            default: id_ex_d.valid = 1'b0;
        endcase

        // undecoded word becomes a nop
        if (!id_ex_d.valid) begin
            id_ex_d        = '0;
            id_ex_d.alu_op = mips_pkg::ALU_NONE;
            use_a          = 1'b0;
            use_b          = 1'b0;
        end
    end

    // load in execute feeding this instruction
    assign hazard_a = use_a && (id_ex_q.dest == inst.r.rs);
    assign hazard_b = use_b && (id_ex_q.dest == inst.r.rt);
    assign stall_o  = id_ex_q.valid && id_ex_q.is_load && (id_ex_q.dest != '0)
                      && (hazard_a || hazard_b);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_q <= '0;
        end else if (stall_o) begin
            id_ex_q <= '0;    // bubble
        end else begin
            id_ex_q <= id_ex_d;
        end
    end

    assign id_ex_o = id_ex_q;

endmodule

// File: hdl/execute_stage.sv
/*
 * alu and load/store address generation
 * execute to memory register, unregistered result for bypass
 */
module execute_stage (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  mips_pkg::id_ex_t   id_ex_i,
    output mips_pkg::wb_t      ex_fwd_o,
    output mips_pkg::ex_mem_t  ex_mem_o
);

    logic [mips_pkg::DATA_W-1:0] result;
    mips_pkg::ex_mem_t           ex_mem_q;

    always_comb begin
        case (id_ex_i.alu_op)
            mips_pkg::ALU_ADD: result = id_ex_i.op_a + id_ex_i.op_b;
            mips_pkg::ALU_SUB: result = id_ex_i.op_a - id_ex_i.op_b;
            mips_pkg::ALU_AND: result = id_ex_i.op_a & id_ex_i.op_b;
            mips_pkg::ALU_OR:  result = id_ex_i.op_a | id_ex_i.op_b;
            mips_pkg::ALU_XOR: result = id_ex_i.op_a ^ id_ex_i.op_b;
            mips_pkg::ALU_SLT: begin
                result = {{(mips_pkg::DATA_W - 1){1'b0}},
                          $signed(id_ex_i.op_a) < $signed(id_ex_i.op_b)};
            end
            mips_pkg::ALU_SLL: result = id_ex_i.op_b << id_ex_i.op_a[4:0];
            mips_pkg::ALU_LUI: result = {id_ex_i.op_b[15:0], 16'h0000};
            default:           result = '0;
        endcase
    end

    // load data not known yet, no bypass from here
    assign ex_fwd_o.we   = id_ex_i.valid && id_ex_i.we && !id_ex_i.is_load;
    assign ex_fwd_o.dest = id_ex_i.dest;
    assign ex_fwd_o.data = result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_mem_q <= '0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.result     <= result;
            ex_mem_q.store_data <= id_ex_i.store_data;
            ex_mem_q.dest       <= id_ex_i.dest;
            ex_mem_q.we         <= id_ex_i.we;
            ex_mem_q.is_load    <= id_ex_i.is_load;
            ex_mem_q.is_store   <= id_ex_i.is_store;
        end
    end

    assign ex_mem_o = ex_mem_q;

endmodule

// File: hdl/fetch_stage.sv
/*
 * program counter, rom strobe and the fetch to decode register
 */
module fetch_stage (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          stall_i,
    input  logic [mips_pkg::DATA_W-1:0]   rom_data_i,
    output logic [31:0]                   rom_addr_o,
    output logic                          rom_ce_o,
    output mips_pkg::fetch_t              fetch_o
);

    logic [31:0]      pc_q;
    logic             ce_q;
    mips_pkg::fetch_t fetch_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q    <= mips_pkg::RESET_PC;
            ce_q    <= 1'b0;
            fetch_q <= '0;    // all-zero word decodes as sll r0 nop
        end else begin
            ce_q <= 1'b1;
            if (ce_q && !stall_i) begin
                pc_q         <= pc_q + 32'd4;
                fetch_q.pc   <= pc_q;
                fetch_q.inst <= rom_data_i;
            end
        end
    end

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = ce_q;
    assign fetch_o    = fetch_q;

endmodule

// File: hdl/memory_stage.sv
/*
 * data ram access and the memory to writeback register
 */
module memory_stage (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  mips_pkg::ex_mem_t             ex_mem_i,
    input  logic [mips_pkg::DATA_W-1:0]   ram_data_i,
    output logic [mips_pkg::DATA_W-1:0]   ram_addr_o,
    output logic [mips_pkg::DATA_W-1:0]   ram_data_o,
    output logic                          ram_we_o,
    output logic                          ram_ce_o,
    output mips_pkg::wb_t                 mem_fwd_o,
    output mips_pkg::wb_t                 wb_o
);

    mips_pkg::wb_t wb_q;

    assign ram_ce_o   = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
    assign ram_we_o   = ex_mem_i.valid && ex_mem_i.is_store;
    assign ram_addr_o = ex_mem_i.result;
    assign ram_data_o = ex_mem_i.store_data;

    // stores and bubbles carry we low
    assign mem_fwd_o.we   = ex_mem_i.valid && ex_mem_i.we;
    assign mem_fwd_o.dest = ex_mem_i.dest;
    assign mem_fwd_o.data = ex_mem_i.is_load ? ram_data_i : ex_mem_i.result;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_fwd_o;
        end
    end

    assign wb_o = wb_q;

endmodule

// File: hdl/mips_core.sv
/*
 * mini_mips top level
 * five stage pipeline, register file, rom and ram ports
 */
module mips_core (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [mips_pkg::DATA_W-1:0]   rom_data_i,
    input  logic [mips_pkg::DATA_W-1:0]   ram_data_i,
    output logic [31:0]                   rom_addr_o,
    output logic                          rom_ce_o,
    output logic [mips_pkg::DATA_W-1:0]   ram_addr_o,
    output logic [mips_pkg::DATA_W-1:0]   ram_data_o,
    output logic                          ram_we_o,
    output logic                          ram_ce_o
);

    mips_pkg::fetch_t                  fetch;
    mips_pkg::id_ex_t                  id_ex;
    mips_pkg::ex_mem_t                 ex_mem;
    mips_pkg::wb_t                     ex_fwd;
    mips_pkg::wb_t                     mem_fwd;
    mips_pkg::wb_t                     wb;
    logic                              stall;
    logic [mips_pkg::REG_ADDR_W-1:0]   raddr_a;
    logic [mips_pkg::REG_ADDR_W-1:0]   raddr_b;
    logic [mips_pkg::DATA_W-1:0]       rdata_a;
    logic [mips_pkg::DATA_W-1:0]       rdata_b;

    fetch_stage u_fetch (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .stall_i    (stall),
        .rom_data_i (rom_data_i),
        .rom_addr_o (rom_addr_o),
        .rom_ce_o   (rom_ce_o),
        .fetch_o    (fetch)
    );

    decode_stage u_decode (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .fetch_i    (fetch),
        .rdata_a_i  (rdata_a),
        .rdata_b_i  (rdata_b),
        .ex_fwd_i   (ex_fwd),
        .mem_fwd_i  (mem_fwd),
        .raddr_a_o  (raddr_a),
        .raddr_b_o  (raddr_b),
        .stall_o    (stall),       // load-use, holds fetch
        .id_ex_o    (id_ex)
    );

    reg_file u_reg_file (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .wb_i       (wb),
        .raddr_a_i  (raddr_a),
        .raddr_b_i  (raddr_b),
        .rdata_a_o  (rdata_a),
        .rdata_b_o  (rdata_b)
    );

    execute_stage u_execute (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .id_ex_i    (id_ex),
        .ex_fwd_o   (ex_fwd),
        .ex_mem_o   (ex_mem)
    );

    memory_stage u_memory (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .ex_mem_i   (ex_mem),
        .ram_data_i (ram_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_ce_o   (ram_ce_o),
        .mem_fwd_o  (mem_fwd),
        .wb_o       (wb)
    );

endmodule

// File: hdl/mips_pkg.sv
/*
 * shared definitions for the mini_mips pipeline
 * widths, opcode and function codes, alu operation enum,
 * instruction views and the stage payload structs
 */
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_NUM    = 32;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // funct field of OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fmt_t;

    // same word, two decodings
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    typedef struct packed {
        logic [31:0] pc;
        inst_u       inst;
    } fetch_t;

    typedef struct packed {
        logic                  valid;
        alu_op_e               alu_op;
        logic [DATA_W-1:0]     op_a;
        logic [DATA_W-1:0]     op_b;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_W-1:0]     result;    // alu result or ram address
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dest;
        logic                  we;
        logic                  is_load;
        logic                  is_store;
    } ex_mem_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage

// File: hdl/reg_file.sv
/*
 * 32 x 32 general purpose registers
 * r0 reads zero, same-cycle writes bypass to the read ports
 */
module reg_file (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    input  mips_pkg::wb_t                     wb_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   raddr_a_i,
    input  logic [mips_pkg::REG_ADDR_W-1:0]   raddr_b_i,
    output logic [mips_pkg::DATA_W-1:0]       rdata_a_o,
    output logic [mips_pkg::DATA_W-1:0]       rdata_b_o
);

    logic [mips_pkg::DATA_W-1:0] regs_q [mips_pkg::REG_NUM];

    function automatic logic [mips_pkg::DATA_W-1:0] read_port(
        input logic [mips_pkg::REG_ADDR_W-1:0] idx,
        input mips_pkg::wb_t                   wb,
        input logic [mips_pkg::DATA_W-1:0]     stored
    );
        logic [mips_pkg::DATA_W-1:0] val;
        if (idx == '0) begin
            val = '0;
        end else if (wb.we && wb.dest == idx) begin
            val = wb.data;    // write-through
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < mips_pkg::REG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.dest != '0) begin
            regs_q[wb_i.dest] <= wb_i.data;
        end
    end

    assign rdata_a_o = read_port(raddr_a_i, wb_i, regs_q[raddr_a_i]);
    assign rdata_b_o = read_port(raddr_b_i, wb_i, regs_q[raddr_b_i]);

endmodule

// File: mini_mips.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_core.sv
testbench/tb_mips_core.sv

// File: testbench/tb_mips_core.sv
/*
 * testbench for the mips_core pipeline
 * rom and ram models, random program generator with an
 * instruction-level reference model, assertions and timeout
 */
module tb_mips_core;

    localparam int          PROG_LEN    = 200;
    localparam int          TIMEOUT_CYC = PROG_LEN + 100;
    localparam int unsigned SEED        = 23497;
    localparam logic [31:0] STORE_BASE  = 32'h0000_0400;
    localparam logic [31:0] END_ADDR    = 32'(4 * (PROG_LEN + 6));  // last sw drained

    logic        clk    = 1'b0;
    logic        arst_n = 1'b0;
    logic [31:0] rom_data;
    logic [31:0] ram_data;
    logic [31:0] rom_addr;
    logic        rom_ce;
    logic [31:0] ram_addr;
    logic [31:0] ram_wdata;
    logic        ram_we;
    logic        ram_ce;

    logic [31:0] rom [1024];
    logic [31:0] ram [1024];
    logic [31:0] ref_mem [1024];
    logic [31:0] ref_rf [32];
    logic [31:0] exp_addr [256];
    logic [31:0] exp_data [256];
    logic [4:0]  hist [3];    // dests of the last three instructions
    int          exp_count   = 0;
    int          exp_stalls  = 0;
    int          store_idx   = 0;
    int          holds       = 0;
    int          run_cyc     = 0;
    int          error_count = 0;
    int          end_errs    = 0;
    logic [31:0] prev_addr   = '0;

    mips_core uut (
        .clk_i      (clk),
        .arst_n_i   (arst_n),
        .rom_data_i (rom_data),
        .ram_data_i (ram_data),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .ram_addr_o (ram_addr),
        .ram_data_o (ram_wdata),
        .ram_we_o   (ram_we),
        .ram_ce_o   (ram_ce)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] fill_word(input int idx);
        return (32'(idx) * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic logic [4:0] rand_reg();
        int unsigned r;
        r = $urandom_range(7, 0);
        return r[4:0];
    endfunction

    // recent destinations make chains at distance 1 to 3 common
    function automatic logic [4:0] pick_src();
        int unsigned r;
        r = $urandom_range(3, 0);
        if (r < 3) begin
            return hist[r[1:0]];
        end
        return rand_reg();
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] funct, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic report_store(input int k, input logic [31:0] addr, input logic [31:0] data);
        error_count++;
        $display("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                 $time, k, data, addr, exp_data[k[7:0]], exp_addr[k[7:0]]);
    endtask

    // fills the rom and runs each instruction on the reference model as it goes
    task automatic build_program();
        logic [31:0] word;
        logic [31:0] val;
        logic [31:0] addr;
        logic [31:0] last_st;
        logic [15:0] imm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [4:0]  prev_ld;
        logic        writes;
        logic        is_ld;
        int          pick;
        int          sel;
        last_st = STORE_BASE;
        prev_ld = '0;
        for (int k = 0; k < 32; k++) begin
            ref_rf[k[4:0]] = '0;
        end
        for (int k = 0; k < 3; k++) begin
            hist[k[1:0]] = '0;
        end
        for (int k = 0; k < 1024; k++) begin
            ref_mem[k[9:0]] = fill_word(k);
            rom[k[9:0]]     = 32'h0;    // sll r0 nop past the end
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            pick   = $urandom_range(99, 0);
            sel    = $urandom_range(6, 0);
            rs     = pick_src();
            rt     = pick_src();
            rd     = rand_reg();
            imm    = 16'($urandom);
            shamt  = 5'($urandom);
            ra     = '0;
            rb     = '0;
            writes = 1'b1;
            is_ld  = 1'b0;
            val    = '0;
            if (i % 4 == 3) begin
                addr = STORE_BASE + 32'(8 * exp_count);    // fresh word each time
                word = i_type(6'h2b, 5'd0, rt, addr[15:0]);
                exp_addr[exp_count[7:0]] = addr;
                exp_data[exp_count[7:0]] = ref_rf[rt];
                ref_mem[addr[11:2]] = ref_rf[rt];
                exp_count++;
                last_st = addr;
                rb      = rt;
                writes  = 1'b0;
            end else if (i % 4 == 0 && pick < 60) begin
                word  = i_type(6'h23, 5'd0, rd, last_st[15:0]);    // reload last store
                val   = ref_mem[last_st[11:2]];
                is_ld = 1'b1;
            end else if (pick < 8) begin
                // undefined encodings behave as nop
                word   = (sel < 3) ? {6'h3f, 26'($urandom)} : r_type(6'h20, rs, rt, rd, 5'd0);
                writes = 1'b0;
            end else if (pick < 20) begin
                addr  = 32'($urandom_range(1023, 0)) << 2;
                word  = i_type(6'h23, 5'd0, rd, addr[15:0]);
                val   = ref_mem[addr[11:2]];
                is_ld = 1'b1;
            end else if (pick < 62) begin
                ra = rs;
                rb = rt;
                word = r_type(6'h21, rs, rt, rd, 5'd0);
                case (sel)
                    0: val = ref_rf[rs] + ref_rf[rt];
                    1: begin
                        word = r_type(6'h23, rs, rt, rd, 5'd0);
                        val  = ref_rf[rs] - ref_rf[rt];
                    end
                    2: begin
                        word = r_type(6'h24, rs, rt, rd, 5'd0);
                        val  = ref_rf[rs] & ref_rf[rt];
                    end
                    3: begin
                        word = r_type(6'h25, rs, rt, rd, 5'd0);
                        val  = ref_rf[rs] | ref_rf[rt];
                    end
                    4: begin
                        word = r_type(6'h26, rs, rt, rd, 5'd0);
                        val  = ref_rf[rs] ^ ref_rf[rt];
                    end
                    5: begin
                        word = r_type(6'h2a, rs, rt, rd, 5'd0);
                        val  = ($signed(ref_rf[rs]) < $signed(ref_rf[rt])) ? 32'd1 : 32'd0;
                    end
                    default: begin
                        ra   = '0;    // sll reads rt only
                        word = r_type(6'h00, 5'd0, rt, rd, shamt);
                        val  = ref_rf[rt] << shamt;
                    end
                endcase
            end else begin
                // i-format ops keep the dest in the rt field
                ra = rs;
                case (sel % 5)
                    0: begin
                        word = i_type(6'h0d, rs, rd, imm);
                        val  = ref_rf[rs] | {16'h0000, imm};
                    end
                    1: begin
                        word = i_type(6'h0c, rs, rd, imm);
                        val  = ref_rf[rs] & {16'h0000, imm};
                    end
                    2: begin
                        word = i_type(6'h0e, rs, rd, imm);
                        val  = ref_rf[rs] ^ {16'h0000, imm};
                    end
                    3: begin
                        word = i_type(6'h09, rs, rd, imm);
                        val  = ref_rf[rs] + {{16{imm[15]}}, imm};
                    end
                    default: begin
                        ra   = '0;
                        word = i_type(6'h0f, 5'd0, rd, imm);
                        val  = {imm, 16'h0000};
                    end
                endcase
            end
            if (prev_ld != '0 && (prev_ld == ra || prev_ld == rb)) begin
                exp_stalls++;    // load-use pair
            end
            prev_ld = is_ld ? rd : 5'd0;
            if (writes && rd != '0) begin
                ref_rf[rd] = val;
            end
            hist[2] = hist[1];
            hist[1] = hist[0];
            hist[0] = writes ? rd : 5'd0;
            rom[i[9:0]] = word;
        end
    endtask

    assign rom_data = rom_ce ? rom[rom_addr[11:2]] : 32'h0;
    assign ram_data = ram[ram_addr[11:2]];

    always @(posedge clk) begin
        if (!arst_n) begin
            for (int k = 0; k < 1024; k++) begin
                ram[k[9:0]] <= fill_word(k);
            end
        end else if (ram_ce && ram_we) begin
            ram[ram_addr[11:2]] <= ram_wdata;
        end
    end

    always @(posedge clk) begin
        if (!arst_n) begin
            run_cyc <= 0;
        end else begin
            run_cyc <= run_cyc + 1;
            if (run_cyc >= 2 && rom_addr == prev_addr) begin
                holds <= holds + 1;
            end
        end
        prev_addr <= rom_addr;
        if (ram_we) begin
            store_idx <= store_idx + 1;
        end
    end

    always @(posedge clk) begin
        if (run_cyc >= TIMEOUT_CYC) begin
            $display("Timeout: program did not drain within %0d cycles", TIMEOUT_CYC);
            $display("Regression failed");
            $finish;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        (!arst_n || !$past(arst_n)) |-> (!ram_we && !ram_ce))
    else begin
        error_count++;
        $display("Error at %0t: ram strobes active around reset", $time);
    end

    first_fetch: assert property (@(posedge clk)
        (arst_n && !$past(arst_n)) |-> (rom_addr == 32'h0))
    else begin
        error_count++;
        $display("Error at %0t: first fetch address %h, expected 0", $time, $sampled(rom_addr));
    end

    rom_enable: assert property (@(posedge clk) (run_cyc >= 1) |-> rom_ce)
    else begin
        error_count++;
        $display("Error at %0t: rom_ce_o low after reset", $time);
    end

    // pc steps by 4 or holds once
    pc_step: assert property (@(posedge clk) (run_cyc >= 2) |->
        (rom_addr == $past(rom_addr) + 32'd4 ||
         (rom_addr == $past(rom_addr) && $past(rom_addr) != $past(rom_addr, 2))))
    else begin
        error_count++;
        $display("Error at %0t: fetch address %h after %h", $time,
                 $sampled(rom_addr), $past(rom_addr));
    end

    store_strobe: assert property (@(posedge clk) ram_we |-> ram_ce)
    else begin
        error_count++;
        $display("Error at %0t: ram_we_o without ram_ce_o", $time);
    end

    no_extra_store: assert property (@(posedge clk) ram_we |-> (store_idx < exp_count))
    else begin
        error_count++;
        $display("Error at %0t: store beyond the %0d expected", $time, exp_count);
    end

    store_match: assert property (@(posedge clk) (ram_we && store_idx < exp_count) |->
        (ram_addr == exp_addr[store_idx[7:0]] && ram_wdata == exp_data[store_idx[7:0]]))
    else begin
        report_store($sampled(store_idx), $sampled(ram_addr), $sampled(ram_wdata));
    end

    initial begin
        void'($urandom(SEED));
        build_program();
        repeat (8) @(posedge clk);
        #1 arst_n = 1'b1;
        while (rom_addr < END_ADDR) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        #1;
        all_stores_seen: assert (store_idx == exp_count)
        else begin
            end_errs++;
            $display("Error at %0t: %0d stores seen, %0d expected", $time, store_idx, exp_count);
        end
        stall_count: assert (holds == exp_stalls)
        else begin
            end_errs++;
            $display("Error at %0t: %0d fetch holds, %0d load-use pairs", $time,
                     holds, exp_stalls);
        end
        $display("stores %0d of %0d, load-use holds %0d of %0d, errors %0d + %0d",
                 store_idx, exp_count, holds, exp_stalls, error_count, end_errs);
        if (error_count == 0 && end_errs == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
